//--- hdl/controlUnit_params.svh
`ifndef CONTROLUNIT_PARAMS_SVH
`define CONTROLUNIT_PARAMS_SVH

`default_nettype none

////////////////////////////////////////////////////////////
// word and state widths.
////////////////////////////////////////////////////////////
`define IR_WIDTH 32
`define STATE_WIDTH 5

////////////////////////////////////////////////////////////
// instruction field positions.
////////////////////////////////////////////////////////////
`define CLASS_MSB 27 // upper bound of the opcode class.
`define CLASS_LSB 25
`define BIT_LOAD 20 // 1 = load, 0 = store.
`define BIT_BYTE 22
`define BIT_UP 23 // 1 = add the offset.
`define BIT_LINK 20 // the load bit, read as link for branches.

`default_nettype wire

`endif

//--- hdl/controlUnitPkg.sv
`include "controlUnit_params.svh"
`default_nettype none

package controlUnitPkg;

	////////////////////////////////////////////////////////////
	// sequencer states.
	////////////////////////////////////////////////////////////
	typedef enum logic [`STATE_WIDTH-1:0] {
		sIdle,
		sFetchAddr,
		sFetchPc,
		sFetchRead,
		sDecode,
		sDpShift,
		sDpFlags,
		sDpImm,
		sBranchLink,
		sBranchTarget,
		sBranchGo,
		sLsAddr,
		sLdRead,
		sLdData,
		sLdWrite,
		sStData,
		sStWrite
	} cuStateT;

	// unsupported opcode classes fold into clsOther.
	typedef enum logic [`CLASS_MSB-`CLASS_LSB:0] {
		clsDpShift = 3'b000,
		clsDpImm = 3'b001,
		clsLsImm = 3'b010,
		clsBranch = 3'b101,
		clsOther = 3'b111
	} instrClassT;

	typedef enum logic [4:0] {
		aluNone = 5'b00000,
		aluPass = 5'b10000,
		aluPcInc = 5'b10001, // pc + 4.
		aluFromIr = 5'b10011,
		aluAdd = 5'b00100,
		aluSub = 5'b00010
	} aluOpT;

endpackage

`default_nettype wire

//--- hdl/instrDecode.sv
`include "controlUnit_params.svh"
`default_nettype none
`timescale 1ns/1ps

module instrDecode
(
	input wire logic [`IR_WIDTH-1:0] ir,
	output controlUnitPkg::instrClassT instrClass,
	output logic isLoad,
	output logic isByte,
	output logic isUp,
	output logic isLink
);
	import controlUnitPkg::*;

	////////////////////////////////////////////////////////////
	// opcode class.
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (ir[`CLASS_MSB:`CLASS_LSB])
			3'b000:
				instrClass = clsDpShift;
			3'b001:
				instrClass = clsDpImm;
			3'b010:
				instrClass = clsLsImm; // immediate offset only.
			3'b101:
				instrClass = clsBranch;
			default:
				instrClass = clsOther; // register offset and the rest.
		endcase
	end

	////////////////////////////////////////////////////////////
	// qualifier bits.
	////////////////////////////////////////////////////////////
	assign isLoad = ir[`BIT_LOAD];
	assign isByte = ir[`BIT_BYTE];
	assign isUp = ir[`BIT_UP];
	assign isLink = ir[`BIT_LINK]; // same bit as isLoad in another class.

endmodule

`default_nettype wire

//--- hdl/cuSequencer.sv
`default_nettype none
`timescale 1ns/1ps

module cuSequencer
(
	input wire logic CLK,
	input wire logic CLR,
	input wire logic condPass,
	input wire logic moc,
	input wire controlUnitPkg::instrClassT instrClass,
	input wire logic isLoad,
	input wire logic isLink,
	output controlUnitPkg::cuStateT state
);
	import controlUnitPkg::*;

	cuStateT nextState;

	////////////////////////////////////////////////////////////
	// state register.
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
			state <= sIdle;
		else
			state <= nextState;
	end

	////////////////////////////////////////////////////////////
	// next state.
	////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = state; // memory waits hold by default.
		case (state)
			sIdle:
				nextState = sFetchAddr;
			sFetchAddr:
				nextState = sFetchPc;
			sFetchPc:
				nextState = sFetchRead;
			sFetchRead:
				if (moc)
					nextState = sDecode;
			sDecode:
			begin
				if (!condPass)
					nextState = sFetchAddr; // condition failed.
				else
				begin
					case (instrClass)
						clsDpShift:
							nextState = sDpShift;
						clsDpImm:
							nextState = sDpImm;
						clsBranch:
							nextState = isLink ? sBranchLink : sBranchTarget;
						clsLsImm:
							nextState = sLsAddr;
						default:
							nextState = sFetchAddr;
					endcase
				end
			end
			sDpShift:
				nextState = sDpFlags;
			sBranchLink:
				nextState = sBranchTarget;
			sBranchTarget:
				nextState = sBranchGo;
			sLsAddr:
				nextState = isLoad ? sLdRead : sStData;
			sLdRead:
				nextState = sLdData;
			sLdData:
				if (moc)
					nextState = sLdWrite;
			sStData:
				nextState = sStWrite;
			sStWrite:
				if (moc)
					nextState = sFetchAddr;
			sDpFlags, sDpImm, sBranchGo, sLdWrite:
				nextState = sFetchAddr; // last step of the instruction.
			default:
				nextState = sIdle;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/controlSignalDecode.sv
`default_nettype none
`timescale 1ns/1ps

module controlSignalDecode
(
	input wire controlUnitPkg::cuStateT state,
	input wire logic isByte,
	input wire logic isUp,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic frLd,
	output logic memEnable,
	output logic memRW,
	output logic memByte,
	output logic mdSel,
	output logic meSel,
	output logic mgSel,
	output logic mhSel,
	output logic shiftEn,
	output logic [1:0] maSel,
	output logic [1:0] mbSel,
	output logic [2:0] mcSel,
	output logic [1:0] mfSel,
	output logic [1:0] miSel,
	output logic [1:0] mjSel,
	output logic [2:0] shiftMode,
	output logic [5:0] shiftSel,
	output controlUnitPkg::aluOpT aluOp
);
	import controlUnitPkg::*;

	////////////////////////////////////////////////////////////
	// load enables and memory request.
	////////////////////////////////////////////////////////////
	assign rfLd = state inside {sFetchPc, sDpShift, sDpFlags, sDpImm, sBranchLink,
		sBranchTarget, sBranchGo, sLdWrite};
	assign irLd = (state == sFetchRead);
	assign marLd = state inside {sFetchAddr, sLsAddr};
	assign mdrLd = state inside {sLdData, sStData};
	assign frLd = state inside {sDpFlags, sDpImm, sBranchTarget};
	assign memEnable = state inside {sFetchPc, sFetchRead, sLdRead, sLdData, sStWrite};
	assign memRW = state inside {sFetchPc, sFetchRead, sLdRead, sLdData}; // 1 = read.
	assign memByte = (state inside {sLdRead, sStWrite}) & isByte;

	////////////////////////////////////////////////////////////
	// datapath selects.
	////////////////////////////////////////////////////////////
	assign mdSel = state inside {sFetchAddr, sFetchPc, sDpShift, sBranchLink, sBranchTarget,
		sBranchGo, sLsAddr, sLdWrite, sStData};
	assign meSel = (state == sStData);
	assign mgSel = 1'b0; // no kept path uses it.
	assign mhSel = (state == sDpImm);
	assign maSel = (state == sBranchLink) ? 2'd3 :
		(state inside {sFetchAddr, sFetchPc, sBranchGo}) ? 2'd2 : 2'd0;
	assign mbSel = (state == sStData) ? 2'd3 :
		(state inside {sLdData, sLdWrite}) ? 2'd2 :
		(state inside {sDpShift, sDpImm, sBranchTarget, sLsAddr}) ? 2'd1 : 2'd0;
	assign mcSel = (state inside {sDpShift, sBranchLink, sBranchTarget}) ? 3'd4 :
		(state == sBranchGo) ? 3'd3 :
		(state == sFetchPc) ? 3'd1 : 3'd0;
	assign mfSel = (state == sBranchTarget) ? 2'd3 : 2'd0;
	assign miSel = (state inside {sLsAddr, sLdRead, sLdData, sLdWrite, sStData, sStWrite})
		? 2'd2 : (state == sDpImm) ? 2'd1 : 2'd0;
	assign mjSel = (state == sBranchTarget) ? 2'd3 :
		(state inside {sDpFlags, sBranchLink, sBranchGo}) ? 2'd1 : 2'd0;

	////////////////////////////////////////////////////////////
	// shifter and ALU.
	////////////////////////////////////////////////////////////
	assign shiftEn = state inside {sDpShift, sBranchTarget};
	assign shiftMode = (state == sBranchTarget) ? 3'd4 :
		(state == sDpShift) ? 3'd1 : 3'd0;
	assign shiftSel = (state inside {sBranchLink, sBranchGo}) ? 6'd4 : 6'd0;

	always_comb
	begin
		case (state)
			sFetchAddr, sStData:
				aluOp = aluPass;
			sFetchPc:
				aluOp = aluPcInc;
			sDpShift, sBranchTarget, sLdWrite:
				aluOp = aluFromIr;
			sBranchLink, sBranchGo:
				aluOp = aluAdd;
			sLsAddr:
			begin
				if (isUp)
					aluOp = aluAdd; // base plus offset.
				else
					aluOp = aluSub;
			end
			default:
				aluOp = aluNone;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`include "controlUnit_params.svh"
`default_nettype none
`timescale 1ns/1ps

module controlUnit
(
	input wire logic CLK,
	input wire logic CLR,
	input wire logic [`IR_WIDTH-1:0] ir,
	input wire logic condPass,
	input wire logic moc,
	output logic rfLd,
	output logic irLd,
	output logic marLd,
	output logic mdrLd,
	output logic frLd,
	output logic memEnable,
	output logic memRW,
	output logic memByte,
	output logic mdSel,
	output logic meSel,
	output logic mgSel,
	output logic mhSel,
	output logic shiftEn,
	output logic [1:0] maSel,
	output logic [1:0] mbSel,
	output logic [2:0] mcSel,
	output logic [1:0] mfSel,
	output logic [1:0] miSel,
	output logic [1:0] mjSel,
	output logic [2:0] shiftMode,
	output logic [5:0] shiftSel,
	output controlUnitPkg::aluOpT aluOp
);
	import controlUnitPkg::*;

	instrClassT instrClass;
	logic isLoad;
	logic isByte;
	logic isUp;
	logic isLink;
	cuStateT state;

	////////////////////////////////////////////////////////////
	// instruction fields, sequencer, output decode.
	////////////////////////////////////////////////////////////
	instrDecode decodeInst
	(
		.ir, .instrClass,
		.isLoad, .isByte, .isUp, .isLink
	);

	cuSequencer seqInst
	(
		.CLK, .CLR,
		.condPass, .moc,
		.instrClass, .isLoad, .isLink,
		.state
	);

	controlSignalDecode ctrlInst
	(
		.state, .isByte, .isUp,
		.rfLd, .irLd, .marLd, .mdrLd, .frLd,
		.memEnable, .memRW, .memByte,
		.mdSel, .meSel, .mgSel, .mhSel,
		.shiftEn, .shiftMode, .shiftSel,
		.maSel, .mbSel, .mcSel, .mfSel, .miSel, .mjSel,
		.aluOp
	);

endmodule

`default_nettype wire

//--- dv/controlUnit_properties.sv
`default_nettype none
`timescale 1ns/1ps

module controlUnitProperties
(
	input wire logic CLK,
	input wire logic CLR,
	input wire logic moc,
	input wire logic memEnable,
	input wire logic memRW,
	input wire logic memByte,
	input wire logic irLd,
	input wire logic mdrLd,
	input wire logic [39:0] outs
);

	resetQuiet: assert property (@(negedge CLK) !CLR |-> outs == '0)
		else $error("control outputs not zero while reset is held");

	// waiting fetch, load data or store write holds its request until moc.
	requestHeld: assert property (@(posedge CLK) disable iff (!CLR)
		memEnable && !moc && (irLd || mdrLd || !memRW) |=> $stable({memEnable, memRW, memByte}))
		else $error("memory request changed before moc");

	singleIrLoad: assert property (@(posedge CLK) disable iff (!CLR)
		irLd && moc |=> !irLd) // one load per fetch.
		else $error("irLd still high after the fetch completed");

endmodule

bind controlUnit controlUnitProperties props
(
	.CLK, .CLR, .moc, .memEnable, .memRW, .memByte, .irLd, .mdrLd,
	.outs({rfLd, irLd, marLd, mdrLd, frLd, memEnable, memRW, memByte, mdSel, meSel, mgSel,
		mhSel, shiftEn, maSel, mbSel, mcSel, mfSel, miSel, mjSel, shiftMode, shiftSel, aluOp})
);

`default_nettype wire

//--- dv/controlUnitTb.sv
`include "controlUnit_params.svh"
`default_nettype none
`timescale 1ns/1ps

module controlUnitTb;
	import controlUnitPkg::*;

	localparam int NUM_INSTR = 320;
	localparam int MAX_CYCLES = 20000;
	localparam int STALL_LIMIT = 10; // longest legal wait is about 5 cycles.
	localparam logic [2:0] CLASS_PICK [10] = '{3'b000, 3'b001, 3'b010, 3'b010, 3'b101,
		3'b101, 3'b011, 3'b100, 3'b110, 3'b111};

	// control outputs in one fixed order.
	typedef struct packed {
		logic rfLd, irLd, marLd, mdrLd, frLd, memEnable, memRW, memByte;
		logic mdSel, meSel, mgSel, mhSel, shiftEn;
		logic [1:0] maSel;
		logic [1:0] mbSel;
		logic [2:0] mcSel;
		logic [1:0] mfSel;
		logic [1:0] miSel;
		logic [1:0] mjSel;
		logic [2:0] shiftMode;
		logic [5:0] shiftSel;
		logic [4:0] aluOp;
	} ctrlT;

	logic CLK;
	logic CLR;
	logic [`IR_WIDTH-1:0] ir;
	logic condPass;
	logic moc;
	logic rfLd, irLd, marLd, mdrLd, frLd, memEnable, memRW, memByte;
	logic mdSel, meSel, mgSel, mhSel, shiftEn;
	logic [1:0] maSel, mbSel, mfSel, miSel, mjSel;
	logic [2:0] mcSel, shiftMode;
	logic [5:0] shiftSel;
	aluOpT aluOp;
	ctrlT got;

	cuStateT modelState;
	cuStateT modelNextState;
	logic [`IR_WIDTH-1:0] irNext;
	logic condNext;
	logic mocNext;
	bit waiting;
	int waitLeft;
	int stall;
	int instrCount;
	int cycle;

	controlUnit dut (.*);

	assign got = {rfLd, irLd, marLd, mdrLd, frLd, memEnable, memRW, memByte, mdSel, meSel,
		mgSel, mhSel, shiftEn, maSel, mbSel, mcSel, mfSel, miSel, mjSel, shiftMode, shiftSel,
		aluOp};

	initial
	begin
		CLK = 1'b0;
		forever
			#10 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////
	// failure reporting and the compare.
	////////////////////////////////////////////////////////////
	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input logic [63:0] value, input logic [63:0] expected,
		input string what);
		if (value !== expected)
			stopRun($sformatf("mismatch at time %0t: %s, got %h, expected %h", $time, what,
				value, expected));
	endtask

	////////////////////////////////////////////////////////////
	// reference model.
	////////////////////////////////////////////////////////////
	function automatic ctrlT expectOutputs(input cuStateT s, input logic byteBit,
		input logic upBit);
		case (s)
			sFetchAddr: return '{marLd: 1, maSel: 2, mdSel: 1, aluOp: aluPass, default: 0};
			sFetchPc: return '{rfLd: 1, memEnable: 1, memRW: 1, maSel: 2, mcSel: 1, mdSel: 1,
				aluOp: aluPcInc, default: 0};
			sFetchRead: return '{irLd: 1, memEnable: 1, memRW: 1, default: 0};
			sDpShift: return '{rfLd: 1, mbSel: 1, mcSel: 4, mdSel: 1, shiftEn: 1,
				shiftMode: 1, aluOp: aluFromIr, default: 0};
			sDpFlags: return '{rfLd: 1, frLd: 1, mjSel: 1, default: 0};
			sDpImm: return '{rfLd: 1, frLd: 1, mbSel: 1, mhSel: 1, miSel: 1, default: 0};
			sBranchLink: return '{rfLd: 1, maSel: 3, mcSel: 4, mdSel: 1, mjSel: 1,
				shiftSel: 4, aluOp: aluAdd, default: 0};
			sBranchTarget: return '{rfLd: 1, frLd: 1, mbSel: 1, mcSel: 4, mdSel: 1, mfSel: 3,
				mjSel: 3, shiftEn: 1, shiftMode: 4, aluOp: aluFromIr, default: 0};
			sBranchGo: return '{rfLd: 1, maSel: 2, mcSel: 3, mdSel: 1, mjSel: 1, shiftSel: 4,
				aluOp: aluAdd, default: 0};
			sLsAddr: return '{marLd: 1, mbSel: 1, mdSel: 1, miSel: 2,
				aluOp: upBit ? aluAdd : aluSub, default: 0};
			sLdRead: return '{memEnable: 1, memRW: 1, memByte: byteBit, miSel: 2, default: 0};
			sLdData: return '{mdrLd: 1, memEnable: 1, memRW: 1, mbSel: 2, miSel: 2, default: 0};
			sLdWrite: return '{rfLd: 1, mbSel: 2, miSel: 2, mdSel: 1, aluOp: aluFromIr,
				default: 0};
			sStData: return '{mdrLd: 1, mbSel: 3, mdSel: 1, meSel: 1, miSel: 2, aluOp: aluPass,
				default: 0};
			sStWrite: return '{memEnable: 1, memByte: byteBit, miSel: 2, default: 0};
			default: return '0; // idle and decode drive nothing.
		endcase
	endfunction

	function automatic cuStateT modelNext(input cuStateT s, input logic [`IR_WIDTH-1:0] instr,
		input logic cond, input logic done);
		case (s)
			sIdle, sDpFlags, sDpImm, sBranchGo, sLdWrite: return sFetchAddr;
			sFetchAddr: return sFetchPc;
			sFetchPc: return sFetchRead;
			sFetchRead: return done ? sDecode : sFetchRead;
			sDecode:
			begin
				if (!cond)
					return sFetchAddr;
				case (instr[`CLASS_MSB:`CLASS_LSB])
					3'b000: return sDpShift;
					3'b001: return sDpImm;
					3'b010: return sLsAddr;
					3'b101: return instr[`BIT_LINK] ? sBranchLink : sBranchTarget;
					default: return sFetchAddr;
				endcase
			end
			sDpShift: return sDpFlags;
			sBranchLink: return sBranchTarget;
			sBranchTarget: return sBranchGo;
			sLsAddr: return instr[`BIT_LOAD] ? sLdRead : sStData;
			sLdRead: return sLdData;
			sLdData: return done ? sLdWrite : sLdData;
			sStData: return sStWrite;
			sStWrite: return done ? sFetchAddr : sStWrite;
			default: return sIdle;
		endcase
	endfunction

	// memory answers 0 to 3 cycles after it sees the request.
	task respondMemory();
		mocNext = 1'b0;
		if (!memEnable || moc)
			waiting = 1'b0; // idle, or the transfer ends at the next edge.
		else
		begin
			if (!waiting)
			begin
				waitLeft = $urandom_range(0, 3);
				waiting = 1'b1;
			end
			if (waitLeft == 0)
				mocNext = 1'b1;
			else
				waitLeft--;
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and checking.
	////////////////////////////////////////////////////////////
	initial
	begin
		void'($urandom(1726));
		CLR = 1'b0;
		ir = '0;
		condPass = 1'b0;
		moc = 1'b0;
		modelState = sIdle;
		waiting = 1'b0;
		waitLeft = 0;
		stall = 0;
		instrCount = 0;
		repeat (3)
			@(posedge CLK);
		CLR <= 1'b1;
		for (cycle = 0; cycle < MAX_CYCLES && instrCount < NUM_INSTR; cycle++)
		begin
			@(negedge CLK);
			checkValue(got, expectOutputs(modelState, ir[`BIT_BYTE], ir[`BIT_UP]),
				$sformatf("outputs in %s", modelState.name()));
			modelNextState = modelNext(modelState, ir, condPass, moc);
			stall = (modelNextState == modelState) ? stall + 1 : 0;
			if (stall > STALL_LIMIT)
				stopRun("timeout: the control unit kept one state for too long");
			irNext = ir;
			condNext = condPass;
			if (irLd && moc)
			begin
				irNext = $urandom();
				irNext[`CLASS_MSB:`CLASS_LSB] = CLASS_PICK[$urandom_range(0, 9)];
				condNext = ($urandom_range(0, 7) != 0); // mostly taken.
				instrCount++;
			end
			respondMemory();
			modelState = modelNextState;
			@(posedge CLK);
			ir <= irNext;
			condPass <= condNext;
			moc <= mocNext;
		end
		if (instrCount >= NUM_INSTR)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			stopRun("timeout: too few instructions finished within the cycle limit");
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/controlUnitPkg.sv
hdl/instrDecode.sv
hdl/cuSequencer.sv
hdl/controlSignalDecode.sv
hdl/controlUnit.sv
dv/controlUnit_properties.sv
dv/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/controlUnitPkg.sv
      - hdl/instrDecode.sv
      - hdl/cuSequencer.sv
      - hdl/controlSignalDecode.sv
      - hdl/controlUnit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/controlUnit_properties.sv
      - dv/controlUnitTb.sv
